// File: project.f
+incdir+src
src/msi_pkg.sv
src/msi_irq_capture.sv
src/msi_rr_arbiter.sv
src/msi_retry_timer.sv
src/msi_send_fsm.sv
src/msi_shim_top.sv
dv/msi_shim_tb.sv

// File: Bender.yml
package:
  name: msi_shim

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/msi_pkg.sv
      - src/msi_irq_capture.sv
      - src/msi_rr_arbiter.sv
      - src/msi_retry_timer.sv
      - src/msi_send_fsm.sv
      - src/msi_shim_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/msi_shim_tb.sv

// File: dv/msi_shim_tb.sv
// Directed testbench for the MSI interrupt shim.
// Holds the clock, reset, a core response model, the directed tests and a run limit.

`timescale 1ns/1ps
`include "msi_defines.svh"

`default_nettype none

module msi_shim_tb import msi_pkg::*; ();

    // The whole run takes well under two thousand cycles.
    localparam int CYCLE_LIMIT = 20000;
    localparam int LOG_DEPTH   = CYCLE_LIMIT + 4;

    logic       clk;
    logic       rst;
    msi_vec_t   msi_irq;
    logic [3:0] msi_enable;
    logic [2:0] msi_mmenable;
    msi_vec_t   msi_mask_data;
    logic       msi_sent;
    logic       msi_fail;
    msi_vec_t   msi_int;
    msi_vec_t   msi_pending_status;
    logic       msi_timeout;

    int          cyc;
    string       test_name;
    logic [31:0] rng_state;

    // Observed MSI pulses and timeout pulses, with the cycle of the latest one.
    int       pulse_total;
    int       pulse_count [`MSI_COUNT];
    msi_vec_t pulse_log [$];
    int       last_pulse_cyc;
    int       timeout_total;
    int       last_timeout_cyc;

    // Core model controls. Drops are used before fails, fails before sends.
    int resp_delay;
    int fail_next;
    int drop_next;
    int fail_cyc;

    // Edges at which pending bits get set by stimulus and cleared by a sent answer.
    msi_vec_t rise_at [LOG_DEPTH];
    msi_vec_t clr_at [LOG_DEPTH];

    msi_shim_top msi_shim_top_inst (
        .clk                (clk),
        .rst                (rst),
        .msi_irq            (msi_irq),
        .msi_enable         (msi_enable),
        .msi_mmenable       (msi_mmenable),
        .msi_mask_data      (msi_mask_data),
        .msi_sent           (msi_sent),
        .msi_fail           (msi_fail),
        .msi_int            (msi_int),
        .msi_pending_status (msi_pending_status),
        .msi_timeout        (msi_timeout)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Cycle count; edge k leaves cyc at k.
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("Run reached the limit of %0d cycles without finishing", CYCLE_LIMIT);
            stop_on_failure();
        end
    end

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    // Checks that a retry did not come inside the hold-off window.
    task automatic check_holdoff(input int event_cyc);
        assert (last_pulse_cyc - event_cyc > `MSI_HOLDOFF) else begin
            $display("Test %s: retry came %0d cycles after the failure, inside the hold-off",
                     test_name, last_pulse_cyc - event_cyc);
            stop_on_failure();
        end
    endtask

    // Xorshift generator for vectors and response delays.
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // All stimulus changes happen 1 ns after the rising edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    // Waits for the pulse count, or the timeout count when on_timeouts is set.
    task automatic wait_for_count(input bit on_timeouts, input int target, input int limit,
                                  input string what);
        int          waited;
        send_state_t st;
        waited = 0;
        while ((on_timeouts ? timeout_total : pulse_total) < target) begin
            step();
            waited++;
            if (waited > limit) begin
                st = msi_shim_top_inst.msi_send_fsm_inst.state;
                $display("Test %s gave up waiting for %s, send FSM in %s",
                         test_name, what, st.name());
                stop_on_failure();
            end
        end
    endtask

    task automatic wait_quiet(input int quiet, input int limit);
        int waited;
        waited = 0;
        while (cyc - last_pulse_cyc < quiet) begin
            step();
            waited++;
            if (waited > limit) begin
                $display("Test %s: msi_int pulses did not stop within %0d cycles",
                         test_name, limit);
                stop_on_failure();
            end
        end
    endtask

    // Pulse monitor, sampled at the falling edge where outputs are settled.
    always @(negedge clk) begin
        if (!rst && msi_int != '0) begin
            assert ($onehot(msi_int)) else begin
                $display("Test %s: msi_int %0h names more than one vector", test_name, msi_int);
                stop_on_failure();
            end
            pulse_total++;
            last_pulse_cyc = cyc;
            pulse_log.push_back(msi_int);
            for (int i = 0; i < `MSI_COUNT; i++) begin
                if (msi_int[i]) begin
                    pulse_count[i]++;
                end
            end
        end
        if (!rst && msi_timeout) begin
            timeout_total++;
            last_timeout_cyc = cyc;
        end
    end

    // One core answer, resp_delay cycles after the pulse, held for one cycle.
    task automatic answer_pulse(input msi_vec_t served);
        repeat (resp_delay) @(posedge clk);
        #1;
        if (drop_next > 0) begin
            drop_next--;
        end else if (fail_next > 0) begin
            fail_next--;
            msi_fail = 1'b1;
            fail_cyc = cyc + 1;
        end else begin
            msi_sent = 1'b1;
            // The DUT clears the pending bit at the edge that samples sent.
            clr_at[cyc + 1] = clr_at[cyc + 1] | served;
        end
        @(posedge clk);
        #1;
        msi_sent = 1'b0;
        msi_fail = 1'b0;
    endtask

    initial begin : core_model
        msi_sent = 1'b0;
        msi_fail = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && msi_int != '0) begin
                answer_pulse(msi_int);
            end
        end
    end

    task automatic test_single();
        int v;
        int base;
        test_name = "test_single";
        v = next_random() % `MSI_COUNT;
        base = pulse_total;
        msi_irq[v] = 1'b1;
        idle(2);
        check_value("msi_pending_status", msi_vec_t'(1) << v, msi_pending_status);
        wait_for_count(0, base + 1, 20, "the msi_int pulse");
        check_value("msi_int vector", msi_vec_t'(1) << v, pulse_log[$]);
        // The sent answer must end the message for good.
        idle(40);
        check_value("pulse count", base + 1, pulse_total);
        msi_irq[v] = 1'b0;
        idle(4);
    endtask

    task automatic test_mask();
        int base;
        int base4;
        int base9;
        test_name = "test_mask";
        base  = pulse_total;
        base4 = pulse_count[4];
        base9 = pulse_count[9];
        // Two vectors enabled, so vector 4 stays pending.
        msi_mmenable = 3'd1;
        idle(1);
        msi_irq[0] = 1'b1;
        msi_irq[1] = 1'b1;
        msi_irq[4] = 1'b1;
        wait_for_count(0, base + 2, 60, "pulses on vectors 0 and 1");
        idle(40);
        check_value("pulses with two vectors enabled", base + 2, pulse_total);
        check_value("pulses on vector 4 out of range", base4, pulse_count[4]);
        // Vector 4 comes into range while the host mask still blocks it.
        msi_mask_data[4] = 1'b1;
        msi_mmenable     = 3'd5;
        idle(40);
        check_value("pulses while vector 4 is masked", base + 2, pulse_total);
        msi_mask_data[4] = 1'b0;
        wait_for_count(0, base + 3, 20, "the pulse on unmasked vector 4");
        idle(40);
        check_value("pulses on vector 4", base4 + 1, pulse_count[4]);
        // With every function disabled a new edge is only held.
        msi_enable = 4'd0;
        msi_irq[9] = 1'b1;
        idle(40);
        check_value("pulses while disabled", base + 3, pulse_total);
        msi_enable = 4'd1;
        wait_for_count(0, base + 4, 20, "the pulse on vector 9");
        idle(40);
        check_value("pulses on vector 9", base9 + 1, pulse_count[9]);
        msi_irq = '0;
        idle(4);
    endtask

    task automatic test_round_robin();
        int base;
        test_name = "test_round_robin";
        // Serving the top vector wraps the pointer back to the bottom.
        base = pulse_total;
        msi_irq[31] = 1'b1;
        wait_for_count(0, base + 1, 20, "the pulse on vector 31");
        idle(10);
        msi_irq[31] = 1'b0;
        pulse_log.delete();
        base = pulse_total;
        msi_irq[3]  = 1'b1;
        msi_irq[7]  = 1'b1;
        msi_irq[20] = 1'b1;
        wait_for_count(0, base + 3, 80, "pulses on vectors 3, 7 and 20");
        idle(30);
        check_value("pulses for three vectors", 3, pulse_log.size());
        check_value("first vector", msi_vec_t'(1) << 3, pulse_log[0]);
        check_value("second vector", msi_vec_t'(1) << 7, pulse_log[1]);
        check_value("third vector", msi_vec_t'(1) << 20, pulse_log[2]);
        // Nothing lies above 20, so the search wraps to vector 2.
        msi_irq[2] = 1'b1;
        wait_for_count(0, base + 4, 20, "the pulse on vector 2");
        idle(30);
        check_value("vector after the wrap", msi_vec_t'(1) << 2, pulse_log[3]);
        check_value("pulse count", base + 4, pulse_total);
        msi_irq = '0;
        idle(4);
    endtask

    task automatic test_fail_retry();
        int v;
        int base;
        test_name = "test_fail_retry";
        v = next_random() % `MSI_COUNT;
        base = pulse_count[v];
        fail_next = 1;
        msi_irq[v] = 1'b1;
        wait_for_count(0, pulse_total + 1, 20, "the first pulse");
        wait_for_count(0, pulse_total + 1, `MSI_HOLDOFF + 30, "the retried pulse");
        check_value("retried vector", msi_vec_t'(1) << v, pulse_log[$]);
        check_holdoff(fail_cyc);
        idle(40);
        check_value("pulses on the failed vector", base + 2, pulse_count[v]);
        msi_irq[v] = 1'b0;
        idle(4);
    endtask

    task automatic test_timeout();
        int v;
        int base;
        int tbase;
        int first_cyc;
        test_name = "test_timeout";
        v = next_random() % `MSI_COUNT;
        base  = pulse_count[v];
        tbase = timeout_total;
        drop_next = 1;
        msi_irq[v] = 1'b1;
        wait_for_count(0, pulse_total + 1, 20, "the first pulse");
        first_cyc = last_pulse_cyc;
        wait_for_count(1, tbase + 1, `MSI_TIMEOUT + 10, "the msi_timeout pulse");
        check_value("cycles from msi_int to msi_timeout", `MSI_TIMEOUT,
                    last_timeout_cyc - first_cyc);
        wait_for_count(0, pulse_total + 1, `MSI_HOLDOFF + 10, "the retried pulse");
        check_value("retried vector", msi_vec_t'(1) << v, pulse_log[$]);
        check_holdoff(last_timeout_cyc);
        idle(40);
        check_value("msi_timeout pulses", tbase + 1, timeout_total);
        check_value("pulses on the vector", base + 2, pulse_count[v]);
        msi_irq[v] = 1'b0;
        idle(4);
    endtask

    task automatic test_random_edges();
        int       v;
        int       rand_start;
        msi_vec_t p;
        msi_vec_t kept;
        int       exp_count [`MSI_COUNT];
        test_name  = "test_random_edges";
        rand_start = cyc;
        for (int i = 0; i < `MSI_COUNT; i++) begin
            pulse_count[i] = 0;
            exp_count[i]   = 0;
        end
        repeat (200) begin
            v = next_random() % `MSI_COUNT;
            if (!msi_irq[v]) begin
                msi_irq[v] = 1'b1;
                // The rise reaches pending two edges after it is driven.
                rise_at[cyc + 2][v] = 1'b1;
            end else if (next_random() % 2 == 0) begin
                msi_irq[v] = 1'b0;
            end
            resp_delay = 1 + next_random() % 6;
            idle(1 + next_random() % 4);
        end
        msi_irq = '0;
        wait_quiet(60, 3000);
        // Replay the recorded sets and clears; an edge on a vector that is
        // still pending merges, and one at its clearing edge starts anew.
        p = '0;
        for (int t = rand_start; t <= cyc; t++) begin
            kept = p & ~clr_at[t];
            for (int i = 0; i < `MSI_COUNT; i++) begin
                if (rise_at[t][i] && !kept[i]) begin
                    exp_count[i]++;
                end
            end
            p = kept | rise_at[t];
        end
        for (int i = 0; i < `MSI_COUNT; i++) begin
            check_value($sformatf("pulses on vector %0d", i), exp_count[i], pulse_count[i]);
        end
    endtask

    initial begin
        rng_state     = 32'd51504;
        rst           = 1'b1;
        msi_irq       = '0;
        msi_enable    = 4'd1;
        msi_mmenable  = 3'd5;
        msi_mask_data = '0;
        resp_delay    = 2;
        fail_next     = 0;
        drop_next     = 0;
        test_name     = "reset";
        for (int t = 0; t < LOG_DEPTH; t++) begin
            rise_at[t] = '0;
            clr_at[t]  = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("msi_int after reset", 0, msi_int);
        check_value("msi_timeout after reset", 0, msi_timeout);
        test_single();
        test_mask();
        test_round_robin();
        test_fail_retry();
        test_timeout();
        test_random_edges();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/msi_shim_top.sv
// Top level of the MSI interrupt shim for physical function 0.
// Connects source capture, round-robin arbiter, retry timer and send FSM.

`timescale 1ns/1ps
`include "msi_defines.svh"

`default_nettype none

module msi_shim_top import msi_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire msi_vec_t   msi_irq,
    input  wire logic [3:0] msi_enable,
    input  wire logic [2:0] msi_mmenable,
    input  wire msi_vec_t   msi_mask_data,
    input  wire logic       msi_sent,
    input  wire logic       msi_fail,
    output msi_vec_t        msi_int,
    output msi_vec_t        msi_pending_status,
    output logic            msi_timeout
);

    msi_vec_t pending;
    msi_vec_t enable_mask;
    msi_vec_t grant;
    logic     grant_valid;
    msi_vec_t acknowledge;
    msi_vec_t clear_vec;
    logic     load_timeout;
    logic     load_holdoff;
    logic     timer_expired;

    msi_irq_capture msi_irq_capture_inst (
        .clk                (clk),
        .rst                (rst),
        .msi_irq            (msi_irq),
        .msi_enable         (msi_enable),
        .msi_mmenable       (msi_mmenable),
        .msi_mask_data      (msi_mask_data),
        .clear_vec          (clear_vec),
        .pending            (pending),
        .enable_mask        (enable_mask),
        .msi_pending_status (msi_pending_status)
    );

    // The held grant is taken out of the request so that it cannot win twice.
    msi_rr_arbiter msi_rr_arbiter_inst (
        .clk         (clk),
        .rst         (rst),
        .request     (pending & enable_mask & ~grant),
        .acknowledge (acknowledge),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    msi_retry_timer msi_retry_timer_inst (
        .clk          (clk),
        .rst          (rst),
        .load_timeout (load_timeout),
        .load_holdoff (load_holdoff),
        .running      (),
        .expired      (timer_expired)
    );

    msi_send_fsm msi_send_fsm_inst (
        .clk          (clk),
        .rst          (rst),
        .msi_enable   (msi_enable),
        .grant        (grant),
        .grant_valid  (grant_valid),
        .msi_sent     (msi_sent),
        .msi_fail     (msi_fail),
        .expired      (timer_expired),
        .msi_int      (msi_int),
        .msi_timeout  (msi_timeout),
        .acknowledge  (acknowledge),
        .clear_vec    (clear_vec),
        .load_timeout (load_timeout),
        .load_holdoff (load_holdoff)
    );

endmodule

`default_nettype wire

// File: src/msi_send_fsm.sv
// Send FSM for the MSI shim.
// Issues one MSI pulse per grant, waits for sent, fail or a timeout, then
// acknowledges the grant and clears or retries the vector.

`timescale 1ns/1ps
`include "msi_defines.svh"

`default_nettype none

module msi_send_fsm import msi_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [3:0] msi_enable,
    input  wire msi_vec_t   grant,
    input  wire logic       grant_valid,
    input  wire logic       msi_sent,
    input  wire logic       msi_fail,
    input  wire logic       expired,
    output msi_vec_t        msi_int,
    output logic            msi_timeout,
    output msi_vec_t        acknowledge,
    output msi_vec_t        clear_vec,
    output logic            load_timeout,
    output logic            load_holdoff
);

    send_state_t state;
    send_state_t state_next;
    msi_vec_t    int_next;
    logic        timeout_next;

    always_comb begin
        state_next   = state;
        int_next     = '0;
        timeout_next = 1'b0;
        acknowledge  = '0;
        clear_vec    = '0;
        load_timeout = 1'b0;
        load_holdoff = 1'b0;
        case (state)
            IDLE: begin
                // Any enabled function permits sending.
                // The timer is loaded here so that a stale expiry from an
                // earlier count can never land in WAIT.
                if (grant_valid && msi_enable != 4'd0) begin
                    int_next     = grant;
                    load_timeout = 1'b1;
                    state_next   = WAIT;
                end
            end
            WAIT: begin
                // Sent has priority over fail and over a timeout in the
                // same cycle, since the message did reach the host.
                if (msi_sent) begin
                    acknowledge = grant;
                    clear_vec   = grant;
                    state_next  = IDLE;
                end else if (msi_fail) begin
                    // The vector stays pending and is retried later.
                    acknowledge  = grant;
                    load_holdoff = 1'b1;
                    state_next   = HOLDOFF;
                end else if (expired) begin
                    timeout_next = 1'b1;
                    acknowledge  = grant;
                    load_holdoff = 1'b1;
                    state_next   = HOLDOFF;
                end
            end
            HOLDOFF: begin
                if (expired) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            msi_int     <= '0;
            msi_timeout <= 1'b0;
        end else begin
            state       <= state_next;
            msi_int     <= int_next;
            msi_timeout <= timeout_next;
        end
    end

    // The core takes exactly one vector per pulse.
    assert property (@(posedge clk) disable iff (rst) $onehot0(msi_int));

    // The core reports one outcome per message.
    assert property (@(posedge clk) disable iff (rst) !(msi_sent && msi_fail));

endmodule

`default_nettype wire

// File: src/msi_retry_timer.sv
// Shared down-counter for the MSI shim.
// Times the wait for a core response and the hold-off after a failure.

`timescale 1ns/1ps
`include "msi_defines.svh"

`default_nettype none

module msi_retry_timer (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic load_timeout,
    input  wire logic load_holdoff,
    output logic      running,
    output logic      expired
);

    localparam int CNT_W = $clog2(`MSI_TIMEOUT + `MSI_HOLDOFF + 1);

    logic [CNT_W-1:0] count;

    // A load in cycle n shows the full count at n+1, so the final cycle with
    // a count of one falls exactly at n plus the loaded value.
    assign running = (count != '0);
    assign expired = (count == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load_timeout) begin
            count <= CNT_W'(`MSI_TIMEOUT);
        end else if (load_holdoff) begin
            count <= CNT_W'(`MSI_HOLDOFF);
        end else if (running) begin
            count <= count - CNT_W'(1);
        end
    end

    // The timeout is armed from IDLE and the hold-off from WAIT, so the send
    // FSM can never ask for both together.
    assert property (@(posedge clk) disable iff (rst) !(load_timeout && load_holdoff));

endmodule

`default_nettype wire

// File: src/msi_rr_arbiter.sv
// Round-robin arbiter for the MSI shim.
// Picks one requesting vector, holds the grant until it is acknowledged and
// then moves its pointer past the served vector.

`timescale 1ns/1ps
`include "msi_defines.svh"

`default_nettype none

module msi_rr_arbiter import msi_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire msi_vec_t request,
    input  wire msi_vec_t acknowledge,
    output msi_vec_t      grant,
    output logic          grant_valid
);

    // Thermometer form of the pointer, ones at and above the first index
    // that the next search may take.
    msi_vec_t ptr_mask;
    msi_vec_t ptr_next;
    msi_vec_t req_upper;
    msi_vec_t pick_upper;
    msi_vec_t pick_any;
    msi_vec_t winner;

    always_comb begin
        req_upper = request & ptr_mask;
        // x & -x isolates the lowest set bit of x.
        pick_upper = req_upper & (~req_upper + msi_vec_t'(1));
        pick_any   = request & (~request + msi_vec_t'(1));
        // Search at or above the pointer first and wrap only when empty.
        if (req_upper != '0) begin
            winner = pick_upper;
        end else begin
            winner = pick_any;
        end
        // Ones strictly above the granted index.
        // When the top vector was served the mask becomes zero, which forces
        // the next search to wrap to the lowest request.
        ptr_next = ~((grant << 1) - msi_vec_t'(1));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            ptr_mask    <= '1;
        end else if (grant_valid) begin
            // The grant stays put until its own bit is acknowledged.
            if ((acknowledge & grant) != '0) begin
                grant       <= '0;
                grant_valid <= 1'b0;
                ptr_mask    <= ptr_next;
            end
        end else if (request != '0) begin
            grant       <= winner;
            grant_valid <= 1'b1;
        end
    end

    // At most one vector is granted at a time.
    assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

    // The valid flag always tracks a nonzero grant.
    assert property (@(posedge clk) disable iff (rst) grant_valid == (grant != '0));

endmodule

`default_nettype wire

// File: src/msi_irq_capture.sv
// Interrupt source capture for the MSI shim.
// Synchronizes the source levels, turns rising edges into sticky pending bits
// and registers the per-vector enable mask.

`timescale 1ns/1ps
`include "msi_defines.svh"

`default_nettype none

module msi_irq_capture import msi_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire msi_vec_t msi_irq,
    input  wire logic [3:0] msi_enable,
    input  wire logic [2:0] msi_mmenable,
    input  wire msi_vec_t msi_mask_data,
    input  wire msi_vec_t clear_vec,
    output msi_vec_t      pending,
    output msi_vec_t      enable_mask,
    output msi_vec_t      msi_pending_status
);

    msi_vec_t irq_sync;
    msi_vec_t irq_last;
    msi_vec_t irq_rise;
    msi_vec_t mm_range;

    // A vector fires once per low-to-high transition of its source.
    assign irq_rise = irq_sync & ~irq_last;

    // The core reports the synchronized levels as pending status.
    assign msi_pending_status = irq_sync;

    // Multiple-message enable grants 2**mmenable vectors.
    // Encodings above 4 exceed one word, so every vector is in range then.
    always_comb begin
        mm_range = '1;
        if (msi_mmenable <= 3'd4) begin
            mm_range = ~(msi_vec_t'('1) << (6'd1 << msi_mmenable));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_sync    <= '0;
            irq_last    <= '0;
            pending     <= '0;
            enable_mask <= '0;
        end else begin
            irq_sync <= msi_irq;
            irq_last <= irq_sync;
            // The clear is applied first so that an edge in the same cycle
            // leaves the vector pending for another message.
            pending <= (pending & ~clear_vec) | irq_rise;
            // A one in the host mask word blocks its vector.
            // Bit 0 of the enable field belongs to physical function 0.
            enable_mask <= ~msi_mask_data & mm_range & {`MSI_COUNT{msi_enable[0]}};
        end
    end

    // The send FSM only clears the vector it was granted, which must still be
    // pending because nothing else clears it.
    assert property (@(posedge clk) disable iff (rst)
        (clear_vec & ~pending) == '0);

endmodule

`default_nettype wire

// File: src/msi_pkg.sv
// Shared types for the MSI interrupt shim.
// Holds the per-vector bit type and the send state encoding.

`include "msi_defines.svh"

`default_nettype none

package msi_pkg;

    // One bit per interrupt vector, bit i belongs to MSI vector i.
    typedef logic [`MSI_COUNT-1:0] msi_vec_t;

    // States of the send FSM.
    // IDLE waits for a grant, WAIT has one message outstanding at the core,
    // and HOLDOFF keeps the bus quiet after a failure or a timeout.
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        WAIT    = 2'd1,
        HOLDOFF = 2'd2
    } send_state_t;

endpackage

`default_nettype wire

// File: src/msi_defines.svh
// Shared sizing and timing macros for the MSI interrupt shim.
// Covers the vector count, the post-failure hold-off and the response timeout.

`ifndef MSI_DEFINES_SVH
`define MSI_DEFINES_SVH

`default_nettype none

// Number of interrupt vectors, one 32-bit MSI word for physical function 0.
`define MSI_COUNT 32

// Idle cycles after a failed or timed-out message before arbitration resumes.
`define MSI_HOLDOFF 16

// Cycles to wait for the core to report sent or fail before giving up.
`define MSI_TIMEOUT 64

`default_nettype wire

`endif
